//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  // The bus and the instruction address are both one machine word wide
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // Number of word entries held by the alignment buffer
  localparam int unsigned BUF_DEPTH = 3;

  // Plain vector types for the widths that carry a meaning
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;

  // Small counter shared by the outstanding and the flush bookkeeping
  typedef logic [1:0] cnt_t;

  // Upper bound on bus requests that are granted but not yet answered
  localparam cnt_t MAX_OUTSTANDING = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // Interface structs
  ////////////////////////////////////////////////////////////////////////////

  // Payload of a fetch request, always a word-aligned address
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // One bus response word with its error bit
  typedef struct packed {
    word_t data;
    logic  err;
  } inst_resp_t;

  // An aligned instruction as handed to the decode stage
  // For compressed instructions the upper halfword is zero filled
  typedef struct packed {
    word_t instr;
    addr_t addr;
    logic  compressed;
    logic  fault;
  } instr_t;

  // Controller outputs seen by the fetch front end
  typedef struct packed {
    logic  pc_set;
    logic  instr_req;
    addr_t branch_addr;
  } ctrl_fsm_t;

endpackage

`default_nettype wire

//--- hw/prefetcher.sv
`timescale 1ns/10ps
`default_nettype none

module prefetcher (
  input  wire                   clk,
  input  wire                   rst_n,
  // Fetch handshake with the alignment buffer
  input  wire                   fetch_valid_i,
  output logic                  fetch_ready_o,
  input  wire                   fetch_branch_i,
  input  wire fetch_pkg::addr_t fetch_branch_addr_i,
  // Instruction bus request channel
  output logic                  bus_req_valid_o,
  output fetch_pkg::fetch_req_t bus_req_o,
  input  wire                   bus_gnt_i
);

  import fetch_pkg::*;

  // Address of the next word to request on the sequential path
  addr_t addr_q;

  // Branch target rounded down to its word
  addr_t branch_word;

  // Address presented on the bus in this cycle
  addr_t req_addr;

  // Set while a request has been shown on the bus without a grant
  logic  pending_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////////////////////////////////////////

  assign branch_word = {fetch_branch_addr_i[ADDR_WIDTH-1:2], 2'b00};

  // A branch takes the bus address in the same cycle
  // Otherwise the stored address is shown and stays put until granted
  assign req_addr = fetch_branch_i ? branch_word : addr_q;

  // A stalled request keeps its valid even if the buffer stops asking
  // A branch drops the stalled request and starts the new path instead
  assign bus_req_valid_o = fetch_valid_i || (pending_q && !fetch_branch_i);

  assign bus_req_o = '{addr: req_addr};

  // The buffer counts a request as outstanding exactly when it is granted
  assign fetch_ready_o = bus_req_valid_o && bus_gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // Address register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q    <= '0;
      pending_q <= 1'b0;
    end else begin
      if (fetch_ready_o) begin
        // Granted, so move on to the word after the one just requested
        addr_q <= req_addr + 32'd4;
      end else if (fetch_branch_i) begin
        // Branch without a grant leaves the target waiting in the register
        addr_q <= branch_word;
      end
      pending_q <= bus_req_valid_o && !bus_gnt_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/alignment_buffer/alignment_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module alignment_buffer (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire fetch_pkg::ctrl_fsm_t  ctrl_fsm_i,
  // Fetch pacing towards the prefetcher
  output logic                       fetch_valid_o,
  input  wire                        fetch_ready_i,
  output logic                       fetch_branch_o,
  output fetch_pkg::addr_t           fetch_branch_addr_o,
  // Bus responses, in request order and without back-pressure
  input  wire                        resp_valid_i,
  input  wire fetch_pkg::inst_resp_t resp_i,
  // Aligned instruction output
  output logic                       instr_valid_o,
  input  wire                        instr_ready_i,
  output fetch_pkg::instr_t          instr_o
);

  import fetch_pkg::*;

  // Word storage and the per-entry valid bits
  inst_resp_t              mem_q [BUF_DEPTH];
  logic [0:BUF_DEPTH-1]    valid_q;
  logic [0:BUF_DEPTH-1]    valid_d;

  // Pointers wrap modulo the buffer depth
  logic [1:0]              wptr_q;
  logic [1:0]              rptr_q;
  logic [1:0]              rptr2;

  // Bus bookkeeping
  cnt_t                    outstanding_cnt_q;
  cnt_t                    n_flush_q;
  cnt_t                    buf_cnt;
  logic [2:0]              fill_level;

  // Position of the next instruction
  logic                    hw_off_q;
  addr_t                   addr_q;

  // Set once an error word has been taken in, fetching stays off until a branch
  logic                    fault_q;

  // Output stage decode
  inst_resp_t              entry0;
  inst_resp_t              entry1;
  logic [15:0]             hw_lo;
  logic                    is_comp;
  logic                    straddle;
  logic                    instr_avail;

  // Events of this cycle
  logic                    resp_accept;
  logic                    pop;
  logic                    pop_word;
  logic                    pop_fault;

  function automatic logic [1:0] ptr_inc(input logic [1:0] ptr);
    ptr_inc = (ptr == 2'(BUF_DEPTH - 1)) ? 2'd0 : ptr + 2'd1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Instruction alignment
  ////////////////////////////////////////////////////////////////////////////

  // The second read pointer names the entry that follows the head
  assign rptr2  = ptr_inc(rptr_q);
  assign entry0 = mem_q[rptr_q];
  assign entry1 = mem_q[rptr2];

  // Halfword at the current offset decides the instruction size
  assign hw_lo   = hw_off_q ? entry0.data[31:16] : entry0.data[15:0];
  assign is_comp = (hw_lo[1:0] != 2'b11);

  // A 32-bit instruction in the upper half spills into the next entry
  assign straddle = !is_comp && hw_off_q;

  // An error word is handed out on its own so a missing second half cannot stall it
  assign instr_avail = valid_q[rptr_q] && (!straddle || valid_q[rptr2] || entry0.err);

  // Nothing is offered in a redirect cycle
  assign instr_valid_o = instr_avail && !ctrl_fsm_i.pc_set;

  always_comb begin
    instr_o.addr       = addr_q;
    instr_o.compressed = is_comp;
    instr_o.fault      = entry0.err || (straddle && valid_q[rptr2] && entry1.err);
    if (is_comp) begin
      instr_o.instr = {16'h0000, hw_lo};
    end else if (hw_off_q) begin
      // Low half comes from the top of the head word
      instr_o.instr = {entry1.data[15:0], entry0.data[31:16]};
    end else begin
      instr_o.instr = entry0.data;
    end
  end

  // A pop releases the head word unless a compressed instruction leaves its upper half
  assign pop       = instr_valid_o && instr_ready_i;
  assign pop_word  = pop && (hw_off_q || !is_comp);
  assign pop_fault = pop && instr_o.fault;

  ////////////////////////////////////////////////////////////////////////////
  // Response intake and fetch pacing
  ////////////////////////////////////////////////////////////////////////////

  // Responses for an abandoned path are counted off and dropped
  // After an error word the rest of the stream is dropped as well
  assign resp_accept = resp_valid_i && !ctrl_fsm_i.pc_set && (n_flush_q == '0) && !fault_q;

  always_comb begin
    buf_cnt = '0;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      buf_cnt = buf_cnt + cnt_t'(valid_q[i]);
    end
  end

  // Words held plus words on the way, less the one leaving now
  assign fill_level = 3'(buf_cnt) + 3'(outstanding_cnt_q) - 3'(pop_word);

  always_comb begin
    if (ctrl_fsm_i.pc_set) begin
      // The buffer empties, so only the bus limit applies to the branch request
      fetch_valid_o = ctrl_fsm_i.instr_req &&
                      ((outstanding_cnt_q - cnt_t'(resp_valid_i)) < MAX_OUTSTANDING);
    end else begin
      // Each new word must find a free entry when it returns
      fetch_valid_o = ctrl_fsm_i.instr_req && !fault_q &&
                      (outstanding_cnt_q < MAX_OUTSTANDING) &&
                      (fill_level <= 3'(BUF_DEPTH - 1));
    end
  end

  assign fetch_branch_o      = ctrl_fsm_i.pc_set;
  assign fetch_branch_addr_o = {ctrl_fsm_i.branch_addr[ADDR_WIDTH-1:1], 1'b0};

  // Free the head on a word pop and claim the tail on a response
  always_comb begin
    valid_d = valid_q;
    if (pop_word) begin
      valid_d[rptr_q] = 1'b0;
    end
    if (resp_accept) begin
      valid_d[wptr_q] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (resp_accept) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q           <= '0;
      wptr_q            <= '0;
      rptr_q            <= '0;
      outstanding_cnt_q <= '0;
      n_flush_q         <= '0;
      hw_off_q          <= 1'b0;
      addr_q            <= '0;
      fault_q           <= 1'b0;
    end else begin
      // Grants add and responses remove, on either path
      outstanding_cnt_q <= outstanding_cnt_q + cnt_t'(fetch_ready_i) - cnt_t'(resp_valid_i);
      if (ctrl_fsm_i.pc_set) begin
        valid_q   <= '0;
        wptr_q    <= '0;
        rptr_q    <= '0;
        fault_q   <= 1'b0;
        // Everything still in flight belongs to the old path
        n_flush_q <= outstanding_cnt_q - cnt_t'(resp_valid_i);
        // Bit 1 of the target skips the lower halfword of the first word
        hw_off_q  <= ctrl_fsm_i.branch_addr[1];
        addr_q    <= {ctrl_fsm_i.branch_addr[ADDR_WIDTH-1:1], 1'b0};
      end else begin
        if (resp_valid_i && (n_flush_q != '0)) begin
          n_flush_q <= n_flush_q - 2'd1;
        end
        if (resp_accept) begin
          wptr_q <= ptr_inc(wptr_q);
          if (resp_i.err) begin
            fault_q <= 1'b1;
          end
        end
        // Nothing may follow a faulting instruction
        if (pop_fault) begin
          valid_q <= '0;
        end else begin
          valid_q <= valid_d;
        end
        if (pop) begin
          addr_q   <= addr_q + (is_comp ? 32'd2 : 32'd4);
          hw_off_q <= is_comp ? !hw_off_q : hw_off_q;
        end
        if (pop_word) begin
          rptr_q <= rptr2;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
  input  wire                       clk,
  input  wire                       rst_n,
  // Controller
  input  wire fetch_pkg::ctrl_fsm_t ctrl_fsm_i,
  // Instruction bus
  output logic                      bus_req_valid_o,
  output fetch_pkg::fetch_req_t     bus_req_o,
  input  wire                       bus_gnt_i,
  input  wire                       bus_rvalid_i,
  input  wire fetch_pkg::inst_resp_t bus_resp_i,
  // Aligned instruction output
  output logic                      instr_valid_o,
  output fetch_pkg::instr_t         instr_o,
  input  wire                       instr_ready_i
);

  import fetch_pkg::*;

  // Pacing and redirect signals between the buffer and the prefetcher
  logic  fetch_valid;
  logic  fetch_ready;
  logic  fetch_branch;
  addr_t fetch_branch_addr;

  // The prefetcher owns the address and talks to the bus request channel
  prefetcher prefetcher_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .bus_req_valid_o     (bus_req_valid_o),
    .bus_req_o           (bus_req_o),
    .bus_gnt_i           (bus_gnt_i)
  );

  // The buffer takes the responses and decides when the next word may be asked for
  alignment_buffer alignment_buffer_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_fsm_i          (ctrl_fsm_i),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (bus_rvalid_i),
    .resp_i              (bus_resp_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_o             (instr_o)
  );

endmodule

`default_nettype wire

//--- tests/fetch_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_model (
  input  wire                        clk,
  input  wire                        rst_n,
  // Request channel from the fetch unit
  input  wire                        req_valid_i,
  input  wire fetch_pkg::fetch_req_t req_i,
  output logic                       gnt_o,
  // Response channel, in request order
  output logic                       rvalid_o,
  output fetch_pkg::inst_resp_t      resp_o,
  // Run-time configuration from the testbench
  input  wire [3:0]                  max_lat_i,
  input  wire                        stall_en_i,
  input  wire fetch_pkg::addr_t      err_lo_i,
  input  wire fetch_pkg::addr_t      err_hi_i
);

  import fetch_pkg::*;

  // 1 KB of instruction memory, indexed by the word address
  word_t       mem [256];

  // Granted requests waiting for their response, with the cycles left for the head
  addr_t       addr_q [$];
  int          lat_q [$];
  addr_t       head;
  logic [31:0] rnd;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Every word of the background fill differs, and ends in a 32-bit opcode pattern
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
    rnd = 32'hb1de_5442;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      resp_o   <= '0;
      addr_q.delete();
      lat_q.delete();
    end else begin
      rvalid_o <= 1'b0;
      // Only the head counts down, so responses leave in request order
      if (addr_q.size() > 0) begin
        if (lat_q[0] <= 1) begin
          head = addr_q.pop_front();
          void'(lat_q.pop_front());
          rvalid_o    <= 1'b1;
          resp_o.data <= mem[head[9:2]];
          resp_o.err  <= (head >= err_lo_i) && (head < err_hi_i);
        end else begin
          lat_q[0] = lat_q[0] - 1;
        end
      end
      if (req_valid_i && gnt_o) begin
        rnd = xorshift(rnd);
        addr_q.push_back(req_i.addr);
        lat_q.push_back(1 + int'(rnd[7:0]) % int'(max_lat_i));
      end
      // Roughly one cycle in four has no grant when stalls are on
      rnd = xorshift(rnd);
      gnt_o <= !stall_en_i || (rnd[1:0] != 2'b00);
    end
  end

endmodule

`default_nettype wire

//--- tests/alignment_checker.sv
`timescale 1ns/10ps
`default_nettype none

module alignment_checker (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire fetch_pkg::ctrl_fsm_t ctrl_fsm_i,
  input  wire                       bus_req_valid_i,
  input  wire fetch_pkg::addr_t     bus_req_addr_i,
  input  wire                       bus_gnt_i,
  input  wire                       resp_valid_i,
  input  wire                       instr_valid_i,
  input  wire                       instr_ready_i,
  input  wire fetch_pkg::addr_t     instr_addr_i,
  // Buffer entry valid bits observed from inside the DUT
  input  wire [2:0]                 buf_valid_i,
  output int                        errors_o
);

  import fetch_pkg::*;

  int    outstanding;
  int    next_outstanding;
  logic  first_pending;
  addr_t first_addr;
  // Word the prefetcher should ask for next on the current path
  addr_t next_req;
  addr_t exp_req;

  // Everything is sampled on the edge, where the DUT outputs have settled
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      errors_o      <= 0;
      outstanding   = 0;
      first_pending = 1'b0;
      first_addr    = '0;
      next_req      = '0;
      exp_req       = '0;
    end else begin
      // Responses cannot be held off, so a full buffer must never see one
      assert (!(resp_valid_i && buf_valid_i == 3'b111))
      else begin
        errors_o <= errors_o + 1;
        $display("Response arrived while all three buffer entries were full");
      end
      assert (!(ctrl_fsm_i.pc_set && instr_valid_i))
      else begin
        errors_o <= errors_o + 1;
        $display("Instruction valid was high in a pc_set cycle");
      end
      // A branch asks for the target word, otherwise requests step one word at a time
      exp_req = ctrl_fsm_i.pc_set ? {ctrl_fsm_i.branch_addr[31:2], 2'b00} : next_req;
      if (bus_req_valid_i) begin
        assert (bus_req_addr_i == exp_req)
        else begin
          errors_o <= errors_o + 1;
          $display("[FAIL] bus_request expected %h actual %h", exp_req, bus_req_addr_i);
        end
      end
      if (bus_req_valid_i && bus_gnt_i) begin
        next_req = exp_req + 32'd4;
      end else if (ctrl_fsm_i.pc_set) begin
        next_req = exp_req;
      end
      // Bus view of requests in flight
      next_outstanding = outstanding + int'(bus_req_valid_i && bus_gnt_i) - int'(resp_valid_i);
      assert (next_outstanding <= 2)
      else begin
        errors_o <= errors_o + 1;
        $display("More than two requests outstanding on the bus");
      end
      outstanding = next_outstanding;
      if (ctrl_fsm_i.pc_set) begin
        first_pending = 1'b1;
        first_addr    = {ctrl_fsm_i.branch_addr[31:1], 1'b0};
      end else if (first_pending && instr_valid_i && instr_ready_i) begin
        assert (instr_addr_i == first_addr)
        else begin
          errors_o <= errors_o + 1;
          $display("[FAIL] first_after_branch expected %h actual %h", first_addr,
                   instr_addr_i);
        end
        first_pending = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int CLK_PERIOD  = 4;
  // Sum of the program lengths of all tests
  localparam int TOTAL_INSTR = 172;
  localparam int MAX_LAT     = 8;

  logic        clk;
  logic        rst_n;
  ctrl_fsm_t   ctrl_fsm;
  logic        bus_req_valid;
  fetch_req_t  bus_req;
  logic        bus_gnt;
  logic        bus_rvalid;
  inst_resp_t  bus_resp;
  logic        instr_valid;
  instr_t      instr;
  logic        instr_ready;

  // Memory model configuration
  logic [3:0]  max_lat;
  logic        stall_en;
  addr_t       err_lo;
  addr_t       err_hi;

  // Scoreboard state
  instr_t      exp_q [$];
  instr_t      exp;
  string       current_test;
  int          sb_errors;
  int          chk_errors;
  logic        check_extra;
  // 0 holds ready low, 1 holds it high, 2 toggles it at random
  int          ready_mode;
  logic [31:0] rnd;
  logic [31:0] ready_rnd;

  fetch_unit fetch_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_fsm_i      (ctrl_fsm),
    .bus_req_valid_o (bus_req_valid),
    .bus_req_o       (bus_req),
    .bus_gnt_i       (bus_gnt),
    .bus_rvalid_i    (bus_rvalid),
    .bus_resp_i      (bus_resp),
    .instr_valid_o   (instr_valid),
    .instr_o         (instr),
    .instr_ready_i   (instr_ready)
  );

  fetch_mem_model mem_model_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (bus_req_valid),
    .req_i       (bus_req),
    .gnt_o       (bus_gnt),
    .rvalid_o    (bus_rvalid),
    .resp_o      (bus_resp),
    .max_lat_i   (max_lat),
    .stall_en_i  (stall_en),
    .err_lo_i    (err_lo),
    .err_hi_i    (err_hi)
  );

  alignment_checker checker_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_fsm_i      (ctrl_fsm),
    .bus_req_valid_i (bus_req_valid),
    .bus_req_addr_i  (bus_req.addr),
    .bus_gnt_i       (bus_gnt),
    .resp_valid_i    (bus_rvalid),
    .instr_valid_i   (instr_valid),
    .instr_ready_i   (instr_ready),
    .instr_addr_i    (instr.addr),
    .buf_valid_i     (fetch_unit_inst.alignment_buffer_inst.valid_q),
    .errors_o        (chk_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_err(input addr_t a);
    return (a >= err_lo) && (a < err_hi);
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Ready is owned by this one process, the tests only pick its mode
  always @(posedge clk) begin
    ready_rnd = xorshift(ready_rnd);
    instr_ready <= (ready_mode == 1) || (ready_mode == 2 && ready_rnd[0]);
  end

  //////////////////////////////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && instr_valid && instr_ready) begin
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        assert (instr == exp)
        else begin
          sb_errors++;
          $display("[FAIL] %s expected %h actual %h", current_test, exp, instr);
        end
      end else begin
        assert (!check_extra)
        else begin
          sb_errors++;
          $display("%s: an instruction was handed out after a fault", current_test);
        end
      end
    end
  end

  // Writes one halfword of the image into the memory model
  task automatic put_half(input addr_t a, input logic [15:0] hw);
    if (a[1]) begin
      mem_model_inst.mem[a[9:2]][31:16] = hw;
    end else begin
      mem_model_inst.mem[a[9:2]][15:0] = hw;
    end
  endtask

  // Lays out a program and queues what the size rule says should come out
  task automatic build_program(input addr_t base, input int n, input bit mix);
    addr_t       a;
    logic [15:0] hw;
    word_t       w;
    instr_t      e;
    a = base;
    for (int i = 0; i < n; i++) begin
      rnd = xorshift(rnd);
      if (mix && rnd[31]) begin
        // Low bits other than 11 mark a compressed instruction
        hw = {rnd[15:2], (rnd[1:0] == 2'b11) ? 2'b01 : rnd[1:0]};
        put_half(a, hw);
        e = '{instr: {16'h0000, hw}, addr: a, compressed: 1'b1, fault: in_err(a)};
        a = a + 2;
      end else begin
        w = {rnd[31:2], 2'b11};
        put_half(a, w[15:0]);
        put_half(a + 2, w[31:16]);
        e = '{instr: w, addr: a, compressed: 1'b0, fault: in_err(a) || in_err(a + 2)};
        a = a + 4;
      end
      exp_q.push_back(e);
      // The stream stops at the first faulting instruction
      if (e.fault) begin
        break;
      end
    end
  endtask

  task automatic issue_branch(input addr_t target);
    @(posedge clk);
    ctrl_fsm.pc_set      <= 1'b1;
    ctrl_fsm.instr_req   <= 1'b1;
    ctrl_fsm.branch_addr <= target;
    @(posedge clk);
    ctrl_fsm.pc_set <= 1'b0;
  endtask

  // Builds, branches and waits until every queued instruction came out
  task automatic run_program(input string name, input addr_t base, input int n,
                             input bit mix, input int mode);
    current_test = name;
    // Ready stays low for a whole cycle before the image and the queue change
    ready_mode   = 0;
    repeat (2) @(posedge clk);
    build_program(base, n, mix);
    issue_branch(base);
    // From here on only the new path can be offered
    ready_mode = mode;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    ready_mode = 0;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic branch_in_flight();
    // Start a path under long latency and leave its words unconsumed
    current_test = "branch_in_flight";
    max_lat      = 4'd8;
    ready_mode   = 0;
    issue_branch(32'h0000_0300);
    while (fetch_unit_inst.alignment_buffer_inst.outstanding_cnt_q != 2'd2) begin
      @(posedge clk);
    end
    build_program(32'h0000_0382, 16, 1'b1);
    issue_branch(32'h0000_0382);
    ready_mode = 1;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    ready_mode = 0;
  endtask

  task automatic fault_window();
    // The word at 0x214 answers with a bus error
    err_lo      = 32'h0000_0214;
    err_hi      = 32'h0000_0218;
    run_program("fault_window", 32'h0000_0200, 12, 1'b0, 1);
    // The faulting instruction was the last one queued, so nothing may follow it
    check_extra = 1'b1;
    ready_mode  = 1;
    repeat (20) @(posedge clk);
    ready_mode  = 0;
    check_extra = 1'b0;
    err_lo      = '0;
    err_hi      = '0;
    run_program("fault_resume", 32'h0000_0280, 16, 1'b1, 1);
  endtask

  // Long enough for every instruction at the worst latency, with room to spare
  initial begin
    #(TOTAL_INSTR * MAX_LAT * 8 * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    rnd          = 32'hb1de_5442;
    ready_rnd    = 32'hb1de_5442;
    rst_n        = 1'b0;
    ctrl_fsm     = '0;
    instr_ready  = 1'b0;
    ready_mode   = 0;
    max_lat      = 4'd1;
    stall_en     = 1'b0;
    err_lo       = '0;
    err_hi       = '0;
    sb_errors    = 0;
    check_extra  = 1'b0;
    current_test = "reset";
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    run_program("straight_32bit", 32'h0000_0040, 24, 1'b0, 1);
    max_lat = 4'd2;
    run_program("mixed_sizes", 32'h0000_0100, 40, 1'b1, 1);
    run_program("halfword_branch", 32'h0000_0202, 16, 1'b1, 1);
    branch_in_flight();
    max_lat  = 4'd4;
    stall_en = 1'b1;
    run_program("backpressure", 32'h0000_0000, 48, 1'b1, 2);
    fault_window();

    repeat (4) @(posedge clk);
    $display("Scoreboard errors: %0d, checker errors: %0d", sb_errors, chk_errors);
    if (sb_errors == 0 && chk_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
common/fetch_pkg.sv
hw/prefetcher.sv
hw/alignment_buffer/alignment_buffer.sv
hw/fetch_unit.sv
tests/fetch_mem_model.sv
tests/alignment_checker.sv
tests/tb_fetch_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_fetch_unit
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
